//--- list.f
src/rv_pkg.sv
src/avalon_if.sv
src/decoder.sv
src/control_unit.sv
src/alu.sv
src/register_file.sv
src/memory_unit.sv
src/cpu_core.sv
src/cpu_top.sv
sim/avalon_mem_model.sv
sim/tb_cpu.sv

//--- sim/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
  import rv_pkg::*;

  // two passes of about 1500 cycles each, with margin for stalls.
  localparam int CYCLE_LIMIT = 6000;
  localparam word_t RESULT_BASE = 32'h0000_0400;

  logic     clk = 1'b0;
  logic     rst = 1'b0;
  logic     stall_en = 1'b0;
  word_t    ibus_address;
  logic     ibus_read;
  logic     ibus_waitrequest;
  word_t    ibus_readdata;
  logic     ibus_readdatavalid;
  word_t    dbus_address;
  logic     dbus_read;
  logic     dbus_write;
  word_t    dbus_writedata;
  byte_en_t dbus_byteenable;
  logic     dbus_waitrequest;
  word_t    dbus_readdata;
  logic     dbus_readdatavalid;
  int       cycles = 0;

  word_t    prog [$];
  word_t    pre_addr [$];
  word_t    pre_data [$];
  word_t    exp_addr [$];
  word_t    exp_data [$];
  byte_en_t exp_be [$];
  int       res_off;

  always #10 clk = ~clk;

  cpu_top DUT (.*);

  avalon_mem_model MEM (.*);

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) abort_run("timeout, the program did not finish in time");
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s expected %h actual %h", what, expected, actual));
    end
  endtask

  task automatic check_byte_en(input string what, input byte_en_t expected,
                               input byte_en_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s expected %b actual %b", what, expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoders and reference rules.
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(input word_t imm, input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd, input opcode_t opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(input word_t imm, input reg_idx_t rd, input opcode_t opc);
    return {imm[31:12], rd, opc};
  endfunction

  function automatic word_t enc_j(input word_t imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic word_t rv_op(input logic [2:0] f3, input logic alt, input word_t a,
                                  input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // program building and running.
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t here();
    return word_t'(prog.size() * 4);
  endfunction

  task automatic emit(input word_t instr);
    prog.push_back(instr);
  endtask

  task automatic expect_write(input word_t addr, input word_t data, input byte_en_t be);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_be.push_back(be);
  endtask

  task automatic new_program();
    prog.delete();
    pre_addr.delete();
    pre_data.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_be.delete();
    res_off = 0;
    emit(enc_i(RESULT_BASE, 0, 3'b000, 31, OPC_OP_IMM));  // x31 points at results.
  endtask

  task automatic store_result(input reg_idx_t rs, input word_t value);
    emit(enc_s(res_off, rs, 31, 3'b010));
    expect_write(RESULT_BASE + res_off, value, 4'b1111);
    res_off += 4;
  endtask

  task automatic load_const(input reg_idx_t rd, input word_t value);
    emit(enc_u(value + 32'h800, rd, OPC_LUI));  // rounds for the signed low part.
    emit(enc_i(value, rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  task automatic load_memory();
    MEM.fill_memory();
    MEM.clear_log();
    foreach (prog[i]) MEM.load_word(word_t'(i * 4), prog[i]);
    foreach (pre_addr[i]) MEM.load_word(pre_addr[i], pre_data[i]);
  endtask

  task automatic start_program(input logic stalled);
    @(posedge clk);
    rst      <= 1'b0;
    stall_en <= stalled;
    for (int c = 0; c < 3; c++) begin
      @(negedge clk);
      if ((ibus_read !== 1'b0) || (dbus_read !== 1'b0) || (dbus_write !== 1'b0)) begin
        abort_run("bus request active during reset");
      end
      if (c == 0) load_memory();
    end
    @(posedge clk);
    rst <= 1'b1;
  endtask

  task automatic run_program(input string name, input logic stalled);
    word_t    addr;
    word_t    data;
    byte_en_t be;
    emit(enc_j(0, 0));  // park on a self-jump.
    start_program(stalled);
    while (MEM.log_size() < exp_addr.size()) @(negedge clk);
    repeat (20) @(negedge clk);
    if (MEM.log_size() != exp_addr.size()) begin
      abort_run($sformatf("%s saw %0d data writes where %0d were expected",
                          name, MEM.log_size(), exp_addr.size()));
    end
    for (int i = 0; i < exp_addr.size(); i++) begin
      MEM.read_log(i, addr, data, be);
      check_word($sformatf("%s write %0d address", name, i), exp_addr[i], addr);
      check_word($sformatf("%s write %0d data", name, i), exp_data[i], data);
      check_byte_en($sformatf("%s write %0d byteenable", name, i), exp_be[i], be);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests.
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int waited;
    waited = 0;
    new_program();
    emit(enc_j(0, 0));
    start_program(1'b0);
    do begin
      @(negedge clk);
      waited++;
    end while ((ibus_read !== 1'b1) && (waited < 4));
    if (ibus_read !== 1'b1) abort_run("no instruction fetch after reset release");
    check_word("reset first fetch address", 32'h0000_0000, ibus_address);
  endtask

  task automatic test_arith(input logic stalled);
    word_t a;
    word_t b;
    word_t imm;
    word_t pc;
    a = 32'h8765_4321;
    b = 32'h0000_0F0D;
    new_program();
    load_const(1, a);
    load_const(2, b);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 2, 1, f, 4));
      store_result(4, rv_op(f, 1'b0, a, b));
    end
    emit(enc_r(7'h20, 2, 1, 3'b000, 4));  // sub.
    store_result(4, rv_op(3'd0, 1'b1, a, b));
    emit(enc_r(7'h20, 2, 1, 3'b101, 4));  // sra.
    store_result(4, rv_op(3'd5, 1'b1, a, b));
    for (int f = 0; f < 8; f++) begin
      imm = ((f == 1) || (f == 5)) ? 32'd7 : 32'hFFFF_FEDD;
      emit(enc_i(imm, 1, f, 5, OPC_OP_IMM));
      store_result(5, rv_op(f, 1'b0, a, imm));
    end
    emit(enc_i(32'h407, 1, 3'b101, 5, OPC_OP_IMM));  // srai.
    store_result(5, rv_op(3'd5, 1'b1, a, 32'd7));
    emit(enc_u(32'hABCD_E000, 6, OPC_LUI));
    store_result(6, 32'hABCD_E000);
    pc = here();
    emit(enc_u(32'h1234_5000, 6, OPC_AUIPC));
    store_result(6, pc + 32'h1234_5000);
    run_program(stalled ? "arith stalled" : "arith", stalled);
  endtask

  task automatic test_loads(input logic stalled);
    word_t       words [0:1];
    word_t       w;
    word_t       off;
    logic [7:0]  bt;
    logic [15:0] hw;
    words = '{32'h80F1_7F23, 32'h7E82_01FF};
    new_program();
    for (int i = 0; i < 2; i++) begin
      off = 32'h300 + 4 * i;
      w   = words[i];
      pre_addr.push_back(RESULT_BASE + off);
      pre_data.push_back(w);
      for (int k = 0; k < 4; k++) begin
        bt = w[8*k +: 8];
        emit(enc_i(off + k, 31, 3'b000, 5, OPC_LOAD));
        store_result(5, {{24{bt[7]}}, bt});
        emit(enc_i(off + k, 31, 3'b100, 5, OPC_LOAD));
        store_result(5, {24'h0, bt});
      end
      for (int k = 0; k < 4; k += 2) begin
        hw = w[8*k +: 16];
        emit(enc_i(off + k, 31, 3'b001, 5, OPC_LOAD));
        store_result(5, {{16{hw[15]}}, hw});
        emit(enc_i(off + k, 31, 3'b101, 5, OPC_LOAD));
        store_result(5, {16'h0, hw});
      end
      emit(enc_i(off, 31, 3'b010, 5, OPC_LOAD));
      store_result(5, w);
    end
    run_program(stalled ? "loads stalled" : "loads", stalled);
  endtask

  task automatic test_stores(input logic stalled);
    word_t    v;
    byte_en_t lane_be [0:3];
    v       = 32'hA1B2_C3D4;
    lane_be = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};
    new_program();
    load_const(1, v);
    for (int k = 0; k < 4; k++) begin
      emit(enc_s(res_off + k, 1, 31, 3'b000));
      expect_write(RESULT_BASE + res_off, {4{v[7:0]}}, lane_be[k]);
      res_off += 4;
    end
    for (int k = 0; k < 4; k += 2) begin
      emit(enc_s(res_off + k, 1, 31, 3'b001));
      expect_write(RESULT_BASE + res_off, {2{v[15:0]}}, (k == 0) ? 4'b0011 : 4'b1100);
      res_off += 4;
    end
    run_program(stalled ? "stores stalled" : "stores", stalled);
  endtask

  task automatic test_control(input logic stalled);
    logic [2:0] conds [0:5];
    int         ra [0:2];
    int         rb [0:2];
    word_t      vals [0:2];
    int         idx;
    logic       taken;
    word_t      pc;
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    ra    = '{1, 2, 2};
    rb    = '{2, 1, 2};
    vals  = '{32'h0, 32'hFFFF_FFFB, 32'd3};  // indexed by register.
    idx   = 0;
    new_program();
    load_const(1, vals[1]);
    emit(enc_i(vals[2], 0, 3'b000, 2, OPC_OP_IMM));
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        taken = branch_rule(conds[c], vals[ra[p]], vals[rb[p]]);
        emit(enc_b(12, rb[p], ra[p], conds[c]));
        emit(enc_i(32'h200 + idx, 0, 3'b000, 7, OPC_OP_IMM));  // fall-through marker.
        emit(enc_j(8, 0));
        emit(enc_i(32'h100 + idx, 0, 3'b000, 7, OPC_OP_IMM));  // taken marker.
        store_result(7, taken ? 32'h100 + idx : 32'h200 + idx);
        idx++;
      end
    end
    pc = here();
    emit(enc_j(8, 8));
    emit(enc_i(1, 0, 3'b000, 9, OPC_OP_IMM));  // skipped.
    store_result(8, pc + 4);
    pc = here() + 4;
    emit(enc_i(pc + 9, 0, 3'b000, 10, OPC_OP_IMM));  // odd target.
    emit(enc_i(0, 10, 3'b000, 11, OPC_JALR));
    emit(enc_i(2, 0, 3'b000, 9, OPC_OP_IMM));  // skipped.
    store_result(11, pc + 4);
    store_result(9, 32'h0);
    run_program(stalled ? "control stalled" : "control", stalled);
  endtask

  initial begin
    test_reset();
    for (int s = 0; s < 2; s++) begin
      test_arith(s);
      test_loads(s);
      test_stores(s);
      test_control(s);
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- sim/avalon_mem_model.sv
`timescale 1ns/1ps

module avalon_mem_model (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall_en,
  input  rv_pkg::word_t    ibus_address,
  input  logic             ibus_read,
  output logic             ibus_waitrequest,
  output rv_pkg::word_t    ibus_readdata,
  output logic             ibus_readdatavalid,
  input  rv_pkg::word_t    dbus_address,
  input  logic             dbus_read,
  input  logic             dbus_write,
  input  rv_pkg::word_t    dbus_writedata,
  input  rv_pkg::byte_en_t dbus_byteenable,
  output logic             dbus_waitrequest,
  output rv_pkg::word_t    dbus_readdata,
  output logic             dbus_readdatavalid
);
  import rv_pkg::*;

  word_t       mem [0:1023];  // 4 KB shared by code and data.
  word_t       log_addr [$];
  word_t       log_data [$];
  byte_en_t    log_be [$];
  logic [31:0] lcg = 32'd44461;
  logic        i_pend;
  logic        d_pend;
  logic [1:0]  i_delay;
  logic [1:0]  d_delay;
  word_t       i_addr;
  word_t       d_addr;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < 1024; i++) mem[i] = word_t'(i) * 32'h9E37_79B9 + 32'h1357_9BDF;
  endtask

  task automatic load_word(input word_t addr, input word_t data);
    mem[addr[11:2]] = data;
  endtask

  task automatic clear_log();
    log_addr.delete();
    log_data.delete();
    log_be.delete();
  endtask

  function automatic int log_size();
    return log_addr.size();
  endfunction

  task automatic read_log(input int i, output word_t addr, output word_t data,
                          output byte_en_t be);
    addr = log_addr[i];
    data = log_data[i];
    be   = log_be[i];
  endtask

  initial begin
    ibus_waitrequest   = 1'b0;
    ibus_readdata      = '0;
    ibus_readdatavalid = 1'b0;
    dbus_waitrequest   = 1'b0;
    dbus_readdata      = '0;
    dbus_readdatavalid = 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // both agents, with random waitrequest and read latency.
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst) begin
    lcg <= lcg_next(lcg);
    if (!rst) begin
      ibus_waitrequest   <= 1'b0;
      ibus_readdatavalid <= 1'b0;
      dbus_waitrequest   <= 1'b0;
      dbus_readdatavalid <= 1'b0;
      i_pend             <= 1'b0;
      d_pend             <= 1'b0;
    end else begin
      ibus_waitrequest   <= stall_en && (lcg[17:16] == 2'b11);  // quarter of cycles.
      dbus_waitrequest   <= stall_en && (lcg[21:20] == 2'b11);
      ibus_readdatavalid <= 1'b0;
      dbus_readdatavalid <= 1'b0;
      if (ibus_read && !ibus_waitrequest) begin
        i_pend  <= 1'b1;
        i_addr  <= ibus_address;
        i_delay <= stall_en ? lcg[25:24] : 2'd0;
      end else if (i_pend && (i_delay != 2'd0)) begin
        i_delay <= i_delay - 2'd1;
      end else if (i_pend) begin
        i_pend             <= 1'b0;
        ibus_readdatavalid <= 1'b1;
        ibus_readdata      <= mem[i_addr[11:2]];
      end
      if (dbus_read && !dbus_waitrequest) begin
        d_pend  <= 1'b1;
        d_addr  <= dbus_address;
        d_delay <= stall_en ? lcg[29:28] : 2'd0;
      end else if (d_pend && (d_delay != 2'd0)) begin
        d_delay <= d_delay - 2'd1;
      end else if (d_pend) begin
        d_pend             <= 1'b0;
        dbus_readdatavalid <= 1'b1;
        dbus_readdata      <= mem[d_addr[11:2]];
      end
      if (dbus_write && !dbus_waitrequest) begin
        for (int b = 0; b < 4; b++) begin
          if (dbus_byteenable[b]) mem[dbus_address[11:2]][8*b +: 8] <= dbus_writedata[8*b +: 8];
        end
        log_addr.push_back(dbus_address);
        log_data.push_back(dbus_writedata);
        log_be.push_back(dbus_byteenable);
      end
    end
  end

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic             clk,
  input  logic             rst,

  // instruction bus.
  output rv_pkg::word_t    ibus_address,
  output logic             ibus_read,
  input  logic             ibus_waitrequest,
  input  rv_pkg::word_t    ibus_readdata,
  input  logic             ibus_readdatavalid,

  // data bus.
  output rv_pkg::word_t    dbus_address,
  output logic             dbus_read,
  output logic             dbus_write,
  output rv_pkg::word_t    dbus_writedata,
  output rv_pkg::byte_en_t dbus_byteenable,
  input  logic             dbus_waitrequest,
  input  rv_pkg::word_t    dbus_readdata,
  input  logic             dbus_readdatavalid
);

  avalon_read_if ibus ();
  avalon_rw_if   dbus ();

  cpu_core u_core (
    .clk  (clk),
    .rst  (rst),
    .ibus (ibus),
    .dbus (dbus)
  );

  assign ibus_address       = ibus.address;
  assign ibus_read          = ibus.read;
  assign ibus.waitrequest   = ibus_waitrequest;
  assign ibus.readdata      = ibus_readdata;
  assign ibus.readdatavalid = ibus_readdatavalid;

  assign dbus_address       = dbus.address;
  assign dbus_read          = dbus.read;
  assign dbus_write         = dbus.write;
  assign dbus_writedata     = dbus.writedata;
  assign dbus_byteenable    = dbus.byteenable;
  assign dbus.waitrequest   = dbus_waitrequest;
  assign dbus.readdata      = dbus_readdata;
  assign dbus.readdatavalid = dbus_readdatavalid;

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input logic         clk,
  input logic         rst,
  avalon_read_if.host ibus,
  avalon_rw_if.host   dbus
);
  import rv_pkg::*;

  word_t     ir;
  word_t     pc;
  word_t     pc_plus4;
  word_t     pc_next;
  opcode_t   opcode;
  reg_idx_t  rd, rs1, rs2;
  logic [2:0] funct3;
  logic      funct7_b5;
  word_t     imm;
  logic      fetch, load_ir;
  alu_op_t   alu_op;
  logic      alu_a_pc, alu_b_imm;
  logic      mem_start_read, mem_start_write, mem_done;
  dest_sel_t dest_sel;
  logic      reg_write, pc_write, pc_jump;
  logic      branch_taken;
  word_t     rs1_data, rs2_data;
  word_t     alu_a, alu_b, alu_result;
  word_t     load_data, rd_data;

  decoder u_decoder (
    .instr(ir), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2),
    .funct3(funct3), .funct7_b5(funct7_b5), .imm(imm)
  );

  control_unit u_control (
    .clk(clk), .rst(rst), .opcode(opcode), .funct3(funct3), .funct7_b5(funct7_b5),
    .branch_taken(branch_taken), .ibus_waitrequest(ibus.waitrequest),
    .ibus_readdatavalid(ibus.readdatavalid), .mem_done(mem_done),
    .fetch(fetch), .load_ir(load_ir), .alu_op(alu_op), .alu_a_pc(alu_a_pc),
    .alu_b_imm(alu_b_imm), .mem_start_read(mem_start_read),
    .mem_start_write(mem_start_write), .dest_sel(dest_sel), .reg_write(reg_write),
    .pc_write(pc_write), .pc_jump(pc_jump)
  );

  register_file u_regs (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .rd_data(rd_data),
    .rd_write(reg_write), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu u_alu (
    .a(alu_a), .b(alu_b), .op(alu_op), .funct3(funct3), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .result(alu_result), .branch_taken(branch_taken)
  );

  memory_unit u_mem (
    .clk(clk), .rst(rst), .start_read(mem_start_read), .start_write(mem_start_write),
    .address(alu_result), .size(mem_size_t'(funct3[1:0])), .unsigned_load(funct3[2]),
    .store_data(rs2_data), .load_data(load_data), .done(mem_done), .bus(dbus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // operand and writeback selects.
  ////////////////////////////////////////////////////////////////////////////

  assign alu_a    = alu_a_pc ? pc : rs1_data;
  assign alu_b    = alu_b_imm ? imm : rs2_data;
  assign pc_plus4 = pc + INSTR_BYTES;
  assign pc_next  = pc_jump ? {alu_result[31:1], 1'b0} : pc_plus4;  // jalr drops bit 0.

  always_comb begin
    case (dest_sel)
      DEST_ALU:  rd_data = alu_result;
      DEST_LOAD: rd_data = load_data;
      DEST_LINK: rd_data = pc_plus4;
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) pc <= RESET_VECTOR;
    else if (pc_write) pc <= pc_next;
  end

  always_ff @(posedge clk) begin
    if (load_ir) ir <= ibus.readdata;
  end

  assign ibus.address = pc;
  assign ibus.read    = fetch;

endmodule

//--- src/memory_unit.sv
`timescale 1ns/1ps

module memory_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              start_read,
  input  logic              start_write,
  input  rv_pkg::word_t     address,
  input  rv_pkg::mem_size_t size,
  input  logic              unsigned_load,
  input  rv_pkg::word_t     store_data,
  output rv_pkg::word_t     load_data,
  output logic              done,
  avalon_rw_if.host         bus
);
  import rv_pkg::*;

  typedef enum logic [1:0] {IDLE, REQUEST, WAIT_DATA} bus_state_e;

  bus_state_e state;
  logic       writing;
  byte_en_t   lanes;
  word_t      read_word;
  word_t      shifted;

  ////////////////////////////////////////////////////////////////////////////
  // byte lanes, little-endian.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (size)
      SIZE_BYTE: begin
        lanes          = byte_en_t'(4'b0001 << address[1:0]);
        bus.writedata  = {4{store_data[7:0]}};
      end
      SIZE_HALF: begin
        lanes          = address[1] ? 4'b1100 : 4'b0011;
        bus.writedata  = {2{store_data[15:0]}};
      end
      default: begin
        lanes          = 4'b1111;
        bus.writedata  = store_data;
      end
    endcase
  end

  assign bus.address    = {address[31:2], 2'b00};
  assign bus.byteenable = lanes;
  assign bus.read       = (state == REQUEST) && !writing;
  assign bus.write      = (state == REQUEST) && writing;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state   <= IDLE;
      writing <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start_read || start_write) begin
            state   <= REQUEST;
            writing <= start_write;
          end
        end
        REQUEST: begin
          if (!bus.waitrequest) begin
            state <= writing ? IDLE : WAIT_DATA;
            done  <= writing;  // writes finish on accept.
          end
        end
        WAIT_DATA: begin
          if (bus.readdatavalid) begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == WAIT_DATA) && bus.readdatavalid) read_word <= bus.readdata;
  end

  assign shifted = read_word >> {address[1:0], 3'b000};

  always_comb begin
    case (size)
      SIZE_BYTE: load_data = {{24{shifted[7] & !unsigned_load}}, shifted[7:0]};
      SIZE_HALF: load_data = {{16{shifted[15] & !unsigned_load}}, shifted[15:0]};
      default:   load_data = read_word;
    endcase
  end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  logic             rd_write,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [1:31];  // x0 has no storage.

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_write && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  input  logic [2:0]      funct3,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);
  import rv_pkg::*;

  logic eq;
  logic lt;
  logic ltu;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << b[4:0];
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {31'b0, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> b[4:0];
      ALU_SRA:    result = word_t'($signed(a) >>> b[4:0]);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // branch compare runs beside the target add.
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      3'b000:  branch_taken = eq;
      3'b001:  branch_taken = !eq;
      3'b100:  branch_taken = lt;
      3'b101:  branch_taken = !lt;
      3'b110:  branch_taken = ltu;
      3'b111:  branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::opcode_t   opcode,
  input  logic [2:0]        funct3,
  input  logic              funct7_b5,
  input  logic              branch_taken,
  input  logic              ibus_waitrequest,
  input  logic              ibus_readdatavalid,
  input  logic              mem_done,
  output logic              fetch,
  output logic              load_ir,
  output rv_pkg::alu_op_t   alu_op,
  output logic              alu_a_pc,
  output logic              alu_b_imm,
  output logic              mem_start_read,
  output logic              mem_start_write,
  output rv_pkg::dest_sel_t dest_sel,
  output logic              reg_write,
  output logic              pc_write,
  output logic              pc_jump
);
  import rv_pkg::*;

  typedef enum logic [1:0] {FETCH, WAIT_INSTR, EXECUTE, MEMORY} cpu_state_e;

  cpu_state_e state;
  cpu_state_e state_next;
  logic       is_mem;
  logic       retire;
  logic       mem_start;  // first cycle of memory.

  assign is_mem  = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
  assign load_ir = (state == WAIT_INSTR) && ibus_readdatavalid;
  assign retire  = ((state == EXECUTE) && !is_mem) || ((state == MEMORY) && mem_done);

  always_comb begin
    state_next = state;
    case (state)
      FETCH:      if (fetch && !ibus_waitrequest) state_next = WAIT_INSTR;
      WAIT_INSTR: if (ibus_readdatavalid) state_next = EXECUTE;
      EXECUTE:    state_next = is_mem ? MEMORY : FETCH;
      MEMORY:     if (mem_done) state_next = FETCH;
      default:    state_next = FETCH;
    endcase
  end

  // state and the registered fetch request.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= FETCH;
      fetch     <= 1'b0;
      mem_start <= 1'b0;
    end else begin
      state     <= state_next;
      fetch     <= (state_next == FETCH);
      mem_start <= (state == EXECUTE) && is_mem;
    end
  end

  assign mem_start_read  = mem_start && (opcode == OPC_LOAD);
  assign mem_start_write = mem_start && (opcode == OPC_STORE);

  ////////////////////////////////////////////////////////////////////////////
  // datapath steering.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op = ALU_ADD;  // address and target adds.
    if (opcode == OPC_LUI) begin
      alu_op = ALU_PASS_B;
    end else if ((opcode == OPC_OP) || (opcode == OPC_OP_IMM)) begin
      case (funct3)
        3'b000:  alu_op = ((opcode == OPC_OP) && funct7_b5) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_SLT;
        3'b011:  alu_op = ALU_SLTU;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM: dest_sel = DEST_ALU;
      OPC_JAL, OPC_JALR:                      dest_sel = DEST_LINK;
      OPC_LOAD:                               dest_sel = DEST_LOAD;
      default:                                dest_sel = DEST_NONE;
    endcase
  end

  assign alu_a_pc  = (opcode == OPC_JAL) || (opcode == OPC_AUIPC) || (opcode == OPC_BRANCH);
  assign alu_b_imm = (opcode != OPC_OP);
  assign reg_write = retire && (dest_sel != DEST_NONE);
  assign pc_write  = retire;
  assign pc_jump   = (opcode == OPC_JAL) || (opcode == OPC_JALR) ||
                     ((opcode == OPC_BRANCH) && branch_taken);

endmodule

//--- src/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  rv_pkg::word_t    instr,
  output rv_pkg::opcode_t  opcode,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output logic [2:0]       funct3,
  output logic             funct7_b5,
  output rv_pkg::word_t    imm
);
  import rv_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign opcode    = instr[6:0];
  assign rd        = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign funct7_b5 = instr[30];  // sub and sra.

  ////////////////////////////////////////////////////////////////////////////
  // immediate layouts, all sign-extended from bit 31.
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OPC_LOAD,
      OPC_OP_IMM,
      OPC_JALR:   imm = imm_i;
      OPC_STORE:  imm = imm_s;
      OPC_BRANCH: imm = imm_b;
      OPC_LUI,
      OPC_AUIPC:  imm = imm_u;
      OPC_JAL:    imm = imm_j;
      default:    imm = '0;  // op has no immediate.
    endcase
  end

endmodule

//--- src/avalon_if.sv
`timescale 1ns/1ps

interface avalon_read_if;
  import rv_pkg::*;

  word_t address;
  logic  read;
  logic  waitrequest;
  word_t readdata;
  logic  readdatavalid;

  modport host  (output address, read, input waitrequest, readdata, readdatavalid);
  modport agent (input address, read, output waitrequest, readdata, readdatavalid);
endinterface

interface avalon_rw_if;
  import rv_pkg::*;

  word_t    address;
  logic     read;
  logic     write;
  word_t    writedata;
  byte_en_t byteenable;
  logic     waitrequest;
  word_t    readdata;
  logic     readdatavalid;

  modport host (output address, read, write, writedata, byteenable,
                input waitrequest, readdata, readdatavalid);
  modport agent (input address, read, write, writedata, byteenable,
                 output waitrequest, readdata, readdatavalid);
endinterface

//--- src/rv_pkg.sv
package rv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths with a meaning.
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // data, address or instruction.
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [3:0]  byte_en_t;   // one bit per data-bus lane.
  typedef logic [1:0]  mem_size_t;
  typedef logic [1:0]  dest_sel_t;  // writeback source.
  typedef logic [6:0]  opcode_t;

  ////////////////////////////////////////////////////////////////////////////
  // encodings.
  ////////////////////////////////////////////////////////////////////////////

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;  // lui.

  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;

  localparam dest_sel_t DEST_NONE = 2'd0;
  localparam dest_sel_t DEST_ALU  = 2'd1;
  localparam dest_sel_t DEST_LOAD = 2'd2;
  localparam dest_sel_t DEST_LINK = 2'd3;  // pc + 4.

  // same as funct3[1:0] of loads and stores.
  localparam mem_size_t SIZE_BYTE = 2'd0;
  localparam mem_size_t SIZE_HALF = 2'd1;
  localparam mem_size_t SIZE_WORD = 2'd2;

  localparam word_t RESET_VECTOR = 32'h0000_0000;
  localparam word_t INSTR_BYTES  = 32'd4;

endpackage
